/* all.f */
+incdir+verilog
+incdir+test
verilog/mcu_cmd_pkg.sv
verilog/cmd_frame_decoder.sv
verilog/cart_config_regs.sv
verilog/mem_access_ctrl.sv
verilog/spi_reply_mux.sv
verilog/mcu_cmd_top.sv
test/tb_mcu_cmd.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f all.f --top-module tb_mcu_cmd -o tb_sim \
  || { echo "build failed"; exit 1; }
out=$(./obj_dir/tb_sim 2>&1)
echo "$out"
echo "$out" | grep -q "Simulation completed successfully" && echo "PASS" || { echo "FAIL"; exit 1; }

/* test/tb_mcu_cmd_tasks.svh */
`ifndef TB_MCU_CMD_TASKS_SVH
`define TB_MCU_CMD_TASKS_SVH

// the command byte always sits at position 1 on the link
task automatic send_cmd(input byte_t op);
  @(posedge clk);
  #1;
  cmd_ready    = 1'b1;
  cmd_data     = op;
  spi_byte_cnt = 32'd1;
  @(posedge clk);
  #1;
  cmd_ready = 1'b0;
endtask

task automatic send_param(input byte_t value, input logic [31:0] pos);
  @(posedge clk);
  #1;
  param_ready  = 1'b1;
  param_data   = value;
  spi_byte_cnt = pos;
  @(posedge clk);
  #1;
  param_ready = 1'b0;
endtask

// command followed by parameter bytes 2, 3 and 4
task automatic send_cmd_with_bytes(input byte_t op, input byte_t b2, input byte_t b3,
                                   input byte_t b4);
  send_cmd(op);
  send_param(b2, 2);
  send_param(b3, 3);
  send_param(b4, 4);
endtask

task automatic settle(input int cycles);
  repeat (cycles) @(negedge clk);
endtask

// rise and fall of mcu_rq_rdy, then the synchronizer and reply latency
task automatic wait_completion;
  int n;
  n = 0;
  @(negedge clk);
  while (mcu_rq_rdy !== 1'b1) begin
    if (n == 20) begin
      $display("timeout: memory model never raised mcu_rq_rdy at %0t ns", $time);
      stop_run();
    end
    n = n + 1;
    @(negedge clk);
  end
  n = 0;
  while (mcu_rq_rdy === 1'b1) begin
    if (n == 10) begin
      $display("timeout: mcu_rq_rdy stuck high at %0t ns", $time);
      stop_run();
    end
    n = n + 1;
    @(negedge clk);
  end
  settle(3);
endtask

`endif

/* test/tb_mcu_cmd.sv */
`timescale 1ns/1ps

module tb_mcu_cmd;
  import mcu_cmd_pkg::*;

  logic        clk;
  logic        rst_n;
  logic        cmd_ready;
  logic        param_ready;
  byte_t       cmd_data;
  byte_t       param_data;
  logic [31:0] spi_byte_cnt;
  logic        mcu_rq_rdy;
  byte_t       mcu_data_in;
  logic        mcu_rrq;
  logic        mcu_wrq;
  mem_addr_t   addr_out;
  byte_t       mcu_data_out;
  cart_cfg_t   cfg;
  byte_t       spi_data_out;

  // memory model
  byte_t       mem [0:255];
  integer      seed = 32'hff0a;
  logic [31:0] rnd;
  logic [8:0]  fill_idx;
  byte_t       req_addr;
  int          wait_cnt;
  int          hold_cnt;

  // request monitor
  logic        rrq_d = 1'b0;
  logic        wrq_d = 1'b0;
  int          rrq_pulses = 0;
  int          wrq_pulses = 0;
  byte_t       wr_expect = 8'h00;

  mem_addr_t   exp_addr;
  byte_t       exp_reply;
  int          pulses_before;
  int          k;

  mcu_cmd_top i_dut (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic stop_run;
    $display("Simulation failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      $display("MISMATCH time=%0t ns signal=%s got=%h expected=%h", $time, name, got, exp);
      stop_run();
    end
  endtask

  `include "tb_mcu_cmd_tasks.svh"

  //////////////////////////////////////////////////////////////////////
  // memory model answering 2 to 6 cycles after a request
  //////////////////////////////////////////////////////////////////////

  initial begin
    mcu_rq_rdy  = 1'b0;
    mcu_data_in = 8'h00;
    wait_cnt    = 0;
    hold_cnt    = 0;
    req_addr    = 8'h00;
    for (fill_idx = 9'd0; fill_idx < 9'd256; fill_idx = fill_idx + 9'd1) begin
      rnd = $random(seed);
      mem[fill_idx[7:0]] = rnd[7:0];
    end
    forever begin
      @(posedge clk);
      #1;
      if (mcu_rrq === 1'b1 || mcu_wrq === 1'b1) begin
        if (mcu_wrq === 1'b1) begin
          mem[addr_out[7:0]] = mcu_data_out;
        end
        req_addr = addr_out[7:0];
        rnd      = $random(seed);
        wait_cnt = 2 + rnd % 5;
      end else if (wait_cnt > 0) begin
        wait_cnt = wait_cnt - 1;
        if (wait_cnt == 0) begin
          mcu_rq_rdy  = 1'b1;
          mcu_data_in = mem[req_addr];
          hold_cnt    = 2;
        end
      end else if (hold_cnt > 0) begin
        hold_cnt = hold_cnt - 1;
        if (hold_cnt == 0) begin
          mcu_rq_rdy = 1'b0;
        end
      end
    end
  end

  // request pulse shape and write data
  always @(negedge clk) begin
    if (rst_n) begin
      assert (!(mcu_rrq && mcu_wrq)) else begin
        $display("read and write requests overlap at %0t ns", $time);
        stop_run();
      end
      assert (!(mcu_rrq && rrq_d) && !(mcu_wrq && wrq_d)) else begin
        $display("a request stayed high longer than one cycle at %0t ns", $time);
        stop_run();
      end
      if (mcu_wrq === 1'b1) begin
        check_value("mcu_data_out", {24'h0, mcu_data_out}, {24'h0, wr_expect});
      end
    end
    rrq_d <= mcu_rrq;
    wrq_d <= mcu_wrq;
    if (mcu_rrq === 1'b1) begin
      rrq_pulses <= rrq_pulses + 1;
    end
    if (mcu_wrq === 1'b1) begin
      wrq_pulses <= wrq_pulses + 1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    rst_n        = 1'b0;
    cmd_ready    = 1'b0;
    param_ready  = 1'b0;
    cmd_data     = 8'h00;
    param_data   = 8'h00;
    spi_byte_cnt = 32'd0;
    repeat (16) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // reset values and a quiet bus
    settle(1);
    check_value("cfg.mapper", {29'h0, cfg.mapper}, 32'd1);
    check_value("addr_out", {8'h0, addr_out}, 32'h0);
    check_value("spi_data_out", {24'h0, spi_data_out}, 32'h0);
    settle(4);
    check_value("mcu_rrq pulses", rrq_pulses, 0);
    check_value("mcu_wrq pulses", wrq_pulses, 0);
    send_cmd(8'h35);
    settle(2);
    check_value("cfg.mapper", {29'h0, cfg.mapper}, 32'd5);

    // mask loads
    send_cmd_with_bytes(8'h10, 8'h12, 8'h34, 8'h56);
    settle(2);
    check_value("cfg.rom_mask", {8'h0, cfg.rom_mask}, 32'h123456);
    send_cmd_with_bytes(8'h20, 8'hAB, 8'hCD, 8'hEF);
    settle(2);
    check_value("cfg.saveram_mask", {8'h0, cfg.saveram_mask}, 32'hABCDEF);
    check_value("cfg.rom_mask", {8'h0, cfg.rom_mask}, 32'h123456);

    // address load and a plain read
    send_cmd_with_bytes(8'h00, 8'h12, 8'h34, 8'h56);
    settle(2);
    exp_addr = 24'h123456;
    check_value("addr_out", {8'h0, addr_out}, {8'h0, exp_addr});
    pulses_before = rrq_pulses;
    exp_reply = mem[exp_addr[7:0]];
    send_cmd(8'h80);
    wait_completion();
    check_value("mcu_rrq pulses", rrq_pulses, pulses_before + 1);
    check_value("spi_data_out", {24'h0, spi_data_out}, {24'h0, exp_reply});
    check_value("addr_out", {8'h0, addr_out}, {8'h0, exp_addr});

    // auto-increment reads from the command and then each parameter byte
    for (k = 0; k < 3; k = k + 1) begin
      exp_reply = mem[exp_addr[7:0]];
      if (k == 0) begin
        send_cmd(8'h88);
      end else begin
        send_param(8'h00, k + 1);
      end
      wait_completion();
      exp_addr = exp_addr + 24'd1;
      check_value("spi_data_out", {24'h0, spi_data_out}, {24'h0, exp_reply});
      check_value("addr_out", {8'h0, addr_out}, {8'h0, exp_addr});
    end

    // auto-increment writes leave the reply alone
    send_cmd(8'h98);
    for (k = 0; k < 2; k = k + 1) begin
      wr_expect = (k == 0) ? 8'h5A : 8'hC7;
      pulses_before = wrq_pulses;
      send_param(wr_expect, k + 2);
      wait_completion();
      check_value("mcu_wrq pulses", wrq_pulses, pulses_before + 1);
      check_value("stored byte", {24'h0, mem[exp_addr[7:0]]}, {24'h0, wr_expect});
      exp_addr = exp_addr + 24'd1;
      check_value("addr_out", {8'h0, addr_out}, {8'h0, exp_addr});
      check_value("spi_data_out", {24'h0, spi_data_out}, {24'h0, exp_reply});
    end

    // signature and then echo of parameters only
    send_cmd(8'hF0);
    settle(2);
    check_value("spi_data_out", {24'h0, spi_data_out}, 32'hA5);
    send_cmd(8'hFF);
    settle(2);
    check_value("spi_data_out", {24'h0, spi_data_out}, 32'hA5);
    send_param(8'h3C, 2);
    settle(2);
    check_value("spi_data_out", {24'h0, spi_data_out}, 32'h3C);
    send_param(8'hC3, 3);
    settle(2);
    check_value("spi_data_out", {24'h0, spi_data_out}, 32'hC3);

    $display("Simulation completed successfully");
    $finish;
  end

endmodule

/* verilog/cart_config_regs.sv */
`timescale 1ns/1ps
`include "mcu_cmd_consts.svh"

module cart_config_regs (
  input  logic                   clk,
  input  logic                   rst_n,
  input  mcu_cmd_pkg::cmd_evt_t  evt,
  output mcu_cmd_pkg::cart_cfg_t cfg
);
  import mcu_cmd_pkg::*;

  logic mapper_sel;
  logic rom_mask_ld;
  logic sram_mask_ld;

  //////////////////////////////////////////////////////////////////////
  // mask byte loading
  //////////////////////////////////////////////////////////////////////

  // bytes 2, 3 and 4 fill the mask from the top down
  function automatic mask_t load_mask_byte(
    input mask_t     cur,
    input byte_idx_t idx,
    input byte_t     data
  );
    mask_t nxt;
    nxt = cur;
    case (idx)
      4'd2: nxt[23:16] = data;
      4'd3: nxt[15:8]  = data;
      4'd4: nxt[7:0]   = data;
      default: nxt = cur;
    endcase
    return nxt;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // event qualification
  //////////////////////////////////////////////////////////////////////

  // mapper comes straight from the command byte
  assign mapper_sel   = evt.is_cmd && (evt.kind == OP_MAPPER);
  assign rom_mask_ld  = evt.is_param && (evt.kind == OP_ROM_MASK);
  assign sram_mask_ld = evt.is_param && (evt.kind == OP_SRAM_MASK);

  //////////////////////////////////////////////////////////////////////
  // config registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cfg.mapper       <= `MCU_MAPPER_RESET;
      cfg.rom_mask     <= '0;
      cfg.saveram_mask <= '0;
    end else begin
      if (mapper_sel) begin
        cfg.mapper <= evt.data[`MCU_MAPPER_W-1:0];
      end
      if (rom_mask_ld) begin
        cfg.rom_mask <= load_mask_byte(cfg.rom_mask, evt.byte_idx, evt.data);
      end
      if (sram_mask_ld) begin
        cfg.saveram_mask <= load_mask_byte(cfg.saveram_mask, evt.byte_idx,
                                           evt.data);
      end
    end
  end

endmodule

/* verilog/cmd_frame_decoder.sv */
`timescale 1ns/1ps
`include "mcu_cmd_consts.svh"

module cmd_frame_decoder (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      cmd_ready,
  input  logic                      param_ready,
  input  mcu_cmd_pkg::byte_t        cmd_data,
  input  mcu_cmd_pkg::byte_t        param_data,
  input  logic [`MCU_SPI_CNT_W-1:0] spi_byte_cnt,
  output mcu_cmd_pkg::cmd_evt_t     evt
);
  import mcu_cmd_pkg::*;

  op_kind_e  cmd_kind;
  op_kind_e  cur_kind_q;
  logic      cur_auto_inc_q;
  logic      cnt_over;
  logic      is_cmd_q;
  logic      is_param_q;
  op_kind_e  kind_q;
  logic      auto_inc_q;
  byte_idx_t byte_idx_q;
  byte_t     data_q;

  // full-byte codes take precedence over the upper nibble
  always_comb begin
    cmd_kind = OP_NONE;
    if (cmd_data == `MCU_OP_SIGNATURE) begin
      cmd_kind = OP_SIGNATURE;
    end else if (cmd_data == `MCU_OP_ECHO) begin
      cmd_kind = OP_ECHO;
    end else begin
      case (cmd_data[7:4])
        `MCU_OP_ADDR:      cmd_kind = OP_SET_ADDR;
        `MCU_OP_ROM_MASK:  cmd_kind = OP_ROM_MASK;
        `MCU_OP_SRAM_MASK: cmd_kind = OP_SRAM_MASK;
        `MCU_OP_MAPPER:    cmd_kind = OP_MAPPER;
        `MCU_OP_READ:      cmd_kind = OP_READ;
        `MCU_OP_WRITE:     cmd_kind = OP_WRITE;
        default:           cmd_kind = OP_NONE;
      endcase
    end
  end

  // anything past 15 is folded onto 15
  assign cnt_over = |spi_byte_cnt[`MCU_SPI_CNT_W-1:`MCU_BYTE_IDX_W];

  // strobes and the class of the running command
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      is_cmd_q       <= 1'b0;
      is_param_q     <= 1'b0;
      cur_kind_q     <= OP_NONE;
      cur_auto_inc_q <= 1'b0;
    end else begin
      is_cmd_q   <= cmd_ready;
      is_param_q <= param_ready & ~cmd_ready;
      if (cmd_ready) begin
        cur_kind_q     <= cmd_kind;
        cur_auto_inc_q <= cmd_data[3];
      end
    end
  end

  // params inherit the class of their command
  always_ff @(posedge clk) begin
    kind_q     <= cmd_ready ? cmd_kind : cur_kind_q;
    auto_inc_q <= cmd_ready ? cmd_data[3] : cur_auto_inc_q;
    byte_idx_q <= cnt_over ? '1 : spi_byte_cnt[`MCU_BYTE_IDX_W-1:0];
    data_q     <= cmd_ready ? cmd_data : param_data;
  end

  assign evt = '{is_cmd: is_cmd_q, is_param: is_param_q, kind: kind_q,
                 auto_inc: auto_inc_q, byte_idx: byte_idx_q, data: data_q};

endmodule

/* verilog/mcu_cmd_consts.svh */
`ifndef MCU_CMD_CONSTS_SVH
`define MCU_CMD_CONSTS_SVH

// data path widths
`define MCU_BYTE_W      8
`define MCU_ADDR_W      24
`define MCU_MAPPER_W    3
`define MCU_SPI_CNT_W   32
`define MCU_BYTE_IDX_W  4

// reply and reset values
`define MCU_SIGNATURE     8'hA5
`define MCU_MAPPER_RESET  3'd1

// opcodes decoded from the upper nibble
`define MCU_OP_ADDR       4'h0
`define MCU_OP_ROM_MASK   4'h1
`define MCU_OP_SRAM_MASK  4'h2
`define MCU_OP_MAPPER     4'h3
`define MCU_OP_READ       4'h8
`define MCU_OP_WRITE      4'h9

// opcodes decoded from the full byte
`define MCU_OP_SIGNATURE  8'hF0
`define MCU_OP_ECHO       8'hFF

`endif

/* verilog/mcu_cmd_pkg.sv */
`include "mcu_cmd_consts.svh"

package mcu_cmd_pkg;

  typedef logic [`MCU_BYTE_W-1:0]     byte_t;
  typedef logic [`MCU_ADDR_W-1:0]     mem_addr_t;
  typedef logic [`MCU_ADDR_W-1:0]     mask_t;
  typedef logic [`MCU_MAPPER_W-1:0]   mapper_t;
  typedef logic [`MCU_BYTE_IDX_W-1:0] byte_idx_t;

  // opcode class of the current command
  typedef enum logic [3:0] {
    OP_SET_ADDR,
    OP_ROM_MASK,
    OP_SRAM_MASK,
    OP_MAPPER,
    OP_READ,
    OP_WRITE,
    OP_SIGNATURE,
    OP_ECHO,
    OP_NONE
  } op_kind_e;

  // decoded byte from the spi link that counts when is_cmd or is_param is set
  typedef struct packed {
    logic      is_cmd;
    logic      is_param;
    op_kind_e  kind;
    logic      auto_inc;
    byte_idx_t byte_idx;
    byte_t     data;
  } cmd_evt_t;

  typedef struct packed {
    mapper_t mapper;
    mask_t   rom_mask;
    mask_t   saveram_mask;
  } cart_cfg_t;

endpackage

/* verilog/mcu_cmd_top.sv */
`timescale 1ns/1ps
`include "mcu_cmd_consts.svh"

module mcu_cmd_top (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      cmd_ready,
  input  logic                      param_ready,
  input  mcu_cmd_pkg::byte_t        cmd_data,
  input  mcu_cmd_pkg::byte_t        param_data,
  input  logic [`MCU_SPI_CNT_W-1:0] spi_byte_cnt,
  input  logic                      mcu_rq_rdy,
  input  mcu_cmd_pkg::byte_t        mcu_data_in,
  output logic                      mcu_rrq,
  output logic                      mcu_wrq,
  output mcu_cmd_pkg::mem_addr_t    addr_out,
  output mcu_cmd_pkg::byte_t        mcu_data_out,
  output mcu_cmd_pkg::cart_cfg_t    cfg,
  output mcu_cmd_pkg::byte_t        spi_data_out
);
  import mcu_cmd_pkg::*;

  cmd_evt_t evt;
  logic     rd_valid;
  byte_t    rd_data;

  // spi strobes to decoded events
  cmd_frame_decoder i_decoder (
    .clk          (clk),
    .rst_n        (rst_n),
    .cmd_ready    (cmd_ready),
    .param_ready  (param_ready),
    .cmd_data     (cmd_data),
    .param_data   (param_data),
    .spi_byte_cnt (spi_byte_cnt),
    .evt          (evt)
  );

  cart_config_regs i_cfg_regs (
    .clk   (clk),
    .rst_n (rst_n),
    .evt   (evt),
    .cfg   (cfg)
  );

  mem_access_ctrl i_mem_ctrl (
    .clk          (clk),
    .rst_n        (rst_n),
    .evt          (evt),
    .mcu_rq_rdy   (mcu_rq_rdy),
    .mcu_data_in  (mcu_data_in),
    .mcu_rrq      (mcu_rrq),
    .mcu_wrq      (mcu_wrq),
    .addr_out     (addr_out),
    .mcu_data_out (mcu_data_out),
    .rd_valid     (rd_valid),
    .rd_data      (rd_data)
  );

  // byte handed back on the next spi transfer
  spi_reply_mux i_reply_mux (
    .clk          (clk),
    .rst_n        (rst_n),
    .evt          (evt),
    .rd_valid     (rd_valid),
    .rd_data      (rd_data),
    .spi_data_out (spi_data_out)
  );

endmodule

/* verilog/mem_access_ctrl.sv */
`timescale 1ns/1ps
`include "mcu_cmd_consts.svh"

module mem_access_ctrl (
  input  logic                  clk,
  input  logic                  rst_n,
  input  mcu_cmd_pkg::cmd_evt_t evt,
  input  logic                  mcu_rq_rdy,
  input  mcu_cmd_pkg::byte_t    mcu_data_in,
  output logic                  mcu_rrq,
  output logic                  mcu_wrq,
  output mcu_cmd_pkg::mem_addr_t addr_out,
  output mcu_cmd_pkg::byte_t    mcu_data_out,
  output logic                  rd_valid,
  output mcu_cmd_pkg::byte_t    rd_data
);
  import mcu_cmd_pkg::*;

  logic  evt_valid;
  logic  rd_req;
  logic  wr_req;
  logic  addr_ld;
  logic  last_is_read;
  logic  last_auto_inc;
  logic  rdy_sync1;
  logic  rdy_sync2;
  logic  rdy_sync2_d;
  logic  rq_done;
  byte_t data_in_d1;
  byte_t data_in_d2;

  assign evt_valid = evt.is_cmd | evt.is_param;
  assign rd_req    = evt_valid && (evt.kind == OP_READ);
  assign wr_req    = evt.is_param && (evt.kind == OP_WRITE);
  assign addr_ld   = evt.is_param && (evt.kind == OP_SET_ADDR);

  //////////////////////////////////////////////////////////////////////
  // request pulses
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      mcu_rrq       <= 1'b0;
      mcu_wrq       <= 1'b0;
      last_is_read  <= 1'b0;
      last_auto_inc <= 1'b0;
    end else begin
      mcu_rrq <= rd_req;
      mcu_wrq <= wr_req;
      // completion always refers to the newest request
      if (rd_req || wr_req) begin
        last_is_read  <= rd_req;
        last_auto_inc <= evt.auto_inc;
      end
    end
  end

  // write data goes out with the wrq pulse
  always_ff @(posedge clk) begin
    if (wr_req) begin
      mcu_data_out <= evt.data;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // completion edge
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rdy_sync1   <= 1'b0;
      rdy_sync2   <= 1'b0;
      rdy_sync2_d <= 1'b0;
    end else begin
      rdy_sync1   <= mcu_rq_rdy;
      rdy_sync2   <= rdy_sync1;
      rdy_sync2_d <= rdy_sync2;
    end
  end

  assign rq_done = rdy_sync2 & ~rdy_sync2_d;

  // read data delayed to line up with rdy_sync2
  always_ff @(posedge clk) begin
    data_in_d1 <= mcu_data_in;
    data_in_d2 <= data_in_d1;
    if (rq_done && last_is_read) begin
      rd_data <= data_in_d2;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_valid <= 1'b0;
    end else begin
      rd_valid <= rq_done && last_is_read;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // address register
  //////////////////////////////////////////////////////////////////////

  // byte 2 sets the bank and clears the rest
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      addr_out <= '0;
    end else if (rq_done && last_auto_inc) begin
      addr_out <= addr_out + 1'b1;
    end else if (addr_ld) begin
      case (evt.byte_idx)
        4'd2: addr_out <= {evt.data, 16'h0000};
        4'd3: addr_out[15:8] <= evt.data;
        4'd4: addr_out[7:0] <= evt.data;
        default: addr_out <= addr_out;
      endcase
    end
  end

endmodule

/* verilog/spi_reply_mux.sv */
`timescale 1ns/1ps
`include "mcu_cmd_consts.svh"

module spi_reply_mux (
  input  logic                  clk,
  input  logic                  rst_n,
  input  mcu_cmd_pkg::cmd_evt_t evt,
  input  logic                  rd_valid,
  input  mcu_cmd_pkg::byte_t    rd_data,
  output mcu_cmd_pkg::byte_t    spi_data_out
);
  import mcu_cmd_pkg::*;

  logic  evt_valid;
  logic  sig_sel;
  logic  echo_sel;
  byte_t reply_nxt;

  assign evt_valid = evt.is_cmd | evt.is_param;

  // signature on any byte of F0, echo only on parameters of FF
  assign sig_sel  = evt_valid && (evt.kind == OP_SIGNATURE);
  assign echo_sel = evt.is_param && (evt.kind == OP_ECHO);

  //////////////////////////////////////////////////////////////////////
  // reply select
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    reply_nxt = spi_data_out;
    if (rd_valid) begin
      // memory data wins over anything from the link
      reply_nxt = rd_data;
    end else if (sig_sel) begin
      reply_nxt = `MCU_SIGNATURE;
    end else if (echo_sel) begin
      reply_nxt = evt.data;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // reply hold register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      spi_data_out <= '0;
    end else begin
      spi_data_out <= reply_nxt;
    end
  end

endmodule
